// File: src/alu_defines.svh
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

`define ALU_W       64
`define ALU_OP_W    13
`define ALU_OPC_W   8
`define ALU_FLAGS_W 6
// carry out of 64, 32, 16, 8 bits and out of bit 3
`define ALU_CARRY_W 5
`define ALU_OVF_W   4
// four zeros, four signs, low byte parity
`define ALU_SZ_W    9

// C O A S Z P from the top
`define ALU_FLAG_C 5
`define ALU_FLAG_O 4
`define ALU_FLAG_A 3
`define ALU_FLAG_S 2
`define ALU_FLAG_Z 1
`define ALU_FLAG_P 0

`define ALU_OP_ADD64    8'd0
`define ALU_OP_ADD32    8'd1
`define ALU_OP_SUB64    8'd2
`define ALU_OP_SUB32    8'd3
`define ALU_OP_CMP16    8'd4
`define ALU_OP_CMP8     8'd5
`define ALU_OP_AND64    8'd8
`define ALU_OP_AND32    8'd9
`define ALU_OP_OR64     8'd10
`define ALU_OP_OR32     8'd11
`define ALU_OP_XOR64    8'd12
`define ALU_OP_XOR32    8'd13
`define ALU_OP_MOV64    8'd16
`define ALU_OP_MOV32    8'd17
`define ALU_OP_ZXT8_64  8'd20
`define ALU_OP_ZXT16_64 8'd21
`define ALU_OP_SXT8_64  8'd22
`define ALU_OP_SXT16_64 8'd23
`define ALU_OP_SXT32_64 8'd24
// conditional pairs, bit 0 set for the inverted form
`define ALU_OP_CMOV64   8'd32
`define ALU_OP_CMOVN64  8'd33
`define ALU_OP_CMOV32   8'd34
`define ALU_OP_CMOVN32  8'd35
`define ALU_OP_CSET     8'd36
`define ALU_OP_CSETN    8'd37

`define ALU_COND_Z   3'd0
`define ALU_COND_S   3'd1
`define ALU_COND_ULE 3'd2
`define ALU_COND_ULT 3'd3
`define ALU_COND_SLE 3'd4
`define ALU_COND_SLT 3'd5
`define ALU_COND_O   3'd6
`define ALU_COND_P   3'd7

`endif

// File: src/alu_op_pkg.sv
`default_nettype none

`include "alu_defines.svh"

package alu_op_pkg;

  typedef struct packed {
    logic       no_flags;
    logic       kill;
    logic [2:0] sub;
    logic [7:0] opcode;
  } alu_view_t;

  // same word seen by the conditional ops
  typedef struct packed {
    logic       no_flags;
    logic       kill;
    logic [2:0] cond_class;
    logic [6:0] opc;
    logic       invert;
  } cond_view_t;

  typedef union packed {
    alu_view_t  alu;
    cond_view_t cond;
  } alu_op_u;

  function automatic logic op_known(logic [`ALU_OPC_W-1:0] opcode);
    return opcode inside {
      `ALU_OP_ADD64, `ALU_OP_ADD32, `ALU_OP_SUB64, `ALU_OP_SUB32,
      `ALU_OP_CMP16, `ALU_OP_CMP8, `ALU_OP_AND64, `ALU_OP_AND32,
      `ALU_OP_OR64, `ALU_OP_OR32, `ALU_OP_XOR64, `ALU_OP_XOR32,
      `ALU_OP_MOV64, `ALU_OP_MOV32, `ALU_OP_ZXT8_64, `ALU_OP_ZXT16_64,
      `ALU_OP_SXT8_64, `ALU_OP_SXT16_64, `ALU_OP_SXT32_64,
      `ALU_OP_CMOV64, `ALU_OP_CMOVN64, `ALU_OP_CMOV32, `ALU_OP_CMOVN32,
      `ALU_OP_CSET, `ALU_OP_CSETN};
  endfunction

endpackage

`default_nettype wire

// File: src/alu_flag_pkg.sv
`default_nettype none

`include "alu_defines.svh"

package alu_flag_pkg;

  // cond is {class, invert}
  function automatic logic cond_holds(logic [`ALU_FLAGS_W-1:0] flags, logic [3:0] cond);
    logic c, o, s, z, p;
    logic hold;
    c    = flags[`ALU_FLAG_C];
    o    = flags[`ALU_FLAG_O];
    s    = flags[`ALU_FLAG_S];
    z    = flags[`ALU_FLAG_Z];
    p    = flags[`ALU_FLAG_P];
    hold = 1'b0;
    case (cond[3:1])
      `ALU_COND_Z:   hold = z;
      `ALU_COND_S:   hold = s;
      `ALU_COND_ULE: hold = c | z;
      `ALU_COND_ULT: hold = c;
      `ALU_COND_SLE: hold = (s ^ o) | z;
      `ALU_COND_SLT: hold = s ^ o;
      `ALU_COND_O:   hold = o;
      `ALU_COND_P:   hold = p;
      default:       hold = 1'b0;
    endcase
    return hold ^ cond[0];
  endfunction

  function automatic logic even_parity8(logic [`ALU_W-1:0] word);
    return ~^word[7:0];
  endfunction

endpackage

`default_nettype wire

// File: src/alu_decode.sv
`default_nettype none

`include "alu_defines.svh"

module alu_decode (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      data_en,
  input  wire                      thread,
  input  wire alu_op_pkg::alu_op_u operation,
  input  wire  [`ALU_W-1:0]        val1,
  input  wire  [`ALU_W-1:0]        val2,
  input  wire  [`ALU_FLAGS_W-1:0]  flags_in,
  input  wire                      except,
  input  wire                      except_thread,
  output logic                     d_valid,
  output logic                     d_thread,
  output logic                     d_kill,
  output logic                     d_no_flags,
  output logic [`ALU_OPC_W-1:0]    d_opcode,
  output logic [`ALU_W-1:0]        d_a,
  output logic [`ALU_W-1:0]        d_b,
  output logic                     d_cond_true,
  output logic [`ALU_FLAGS_W-1:0]  d_flags_in
);
  import alu_op_pkg::*;
  import alu_flag_pkg::*;

  logic hit;
  logic is_cond;
  logic cond_now;

  if ($bits(alu_op_u) != `ALU_OP_W) begin : g_op_w
    $error("operation word is not %0d bits", `ALU_OP_W);
  end

  // exception on the entry cycle
  assign hit = except && (except_thread == thread);

  // cmov64, cmov32 and cset families, invert bit dropped
  assign is_cond = operation.cond.opc inside {
    `ALU_OP_CMOV64 >> 1, `ALU_OP_CMOV32 >> 1, `ALU_OP_CSET >> 1};

  assign cond_now = cond_holds(flags_in, {operation.cond.cond_class, operation.cond.invert});

  always_ff @(posedge clk) begin
    if (rst) begin
      d_valid    <= 1'b0;
      d_kill     <= 1'b0;
      d_no_flags <= 1'b0;
    end else begin
      d_valid    <= data_en && !hit;
      d_kill     <= operation.alu.kill;
      d_no_flags <= operation.alu.no_flags;
    end
  end

  always_ff @(posedge clk) begin
    d_thread    <= thread;
    d_opcode    <= operation.alu.opcode;
    d_a         <= val1;
    d_b         <= val2;
    d_cond_true <= is_cond && cond_now;
    d_flags_in  <= flags_in; // for conditional ops
  end

  a_known_op: assert property (@(posedge clk) disable iff (rst)
    d_valid |-> op_known(d_opcode));

endmodule

`default_nettype wire

// File: src/alu_exec.sv
`default_nettype none

`include "alu_defines.svh"

module alu_exec (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      d_valid,
  input  wire                      d_thread,
  input  wire                      d_kill,
  input  wire                      d_no_flags,
  input  wire  [`ALU_OPC_W-1:0]    d_opcode,
  input  wire  [`ALU_W-1:0]        d_a,
  input  wire  [`ALU_W-1:0]        d_b,
  input  wire                      d_cond_true,
  input  wire  [`ALU_FLAGS_W-1:0]  d_flags_in,
  input  wire                      except,
  input  wire                      except_thread,
  output logic                     x_valid,
  output logic                     x_thread,
  output logic                     x_kill,
  output logic                     x_no_flags,
  output logic [`ALU_OPC_W-1:0]    x_opcode,
  output logic [`ALU_W-1:0]        x_result,
  output logic [`ALU_CARRY_W-1:0]  x_carry,
  output logic [`ALU_OVF_W-1:0]    x_ovf,
  output logic [`ALU_SZ_W-1:0]     x_sign_zero
);
  import alu_flag_pkg::*;

  logic                    hit, valid_next;
  logic                    sub_op, half;
  logic                    sel_add, sel_and, sel_or, sel_xor;
  logic                    sel_mov, sel_ext, sel_cmov, sel_cset;
  logic [`ALU_W-1:0]       b_eff;
  logic [`ALU_W:0]         a_x, b_x, sum;
  logic [`ALU_W-1:0]       ext_val, res_full, res_next;
  logic [`ALU_CARRY_W-1:0] carry;
  logic [`ALU_OVF_W-1:0]   ovf;
  logic [3:0]              zero, sign;

  assign hit        = except && (except_thread == d_thread);
  assign valid_next = d_valid && !hit;

  assign sub_op   = d_opcode inside {`ALU_OP_SUB64, `ALU_OP_SUB32, `ALU_OP_CMP16, `ALU_OP_CMP8};
  assign sel_add  = sub_op || (d_opcode inside {`ALU_OP_ADD64, `ALU_OP_ADD32});
  assign sel_and  = d_opcode inside {`ALU_OP_AND64, `ALU_OP_AND32};
  assign sel_or   = d_opcode inside {`ALU_OP_OR64, `ALU_OP_OR32};
  assign sel_xor  = d_opcode inside {`ALU_OP_XOR64, `ALU_OP_XOR32};
  assign sel_mov  = d_opcode inside {`ALU_OP_MOV64, `ALU_OP_MOV32};
  assign sel_ext  = d_opcode inside {`ALU_OP_ZXT8_64, `ALU_OP_ZXT16_64, `ALU_OP_SXT8_64,
                                     `ALU_OP_SXT16_64, `ALU_OP_SXT32_64};
  assign sel_cmov = d_opcode inside {`ALU_OP_CMOV64, `ALU_OP_CMOVN64,
                                     `ALU_OP_CMOV32, `ALU_OP_CMOVN32};
  assign sel_cset = d_opcode inside {`ALU_OP_CSET, `ALU_OP_CSETN};
  assign half     = d_opcode inside {`ALU_OP_ADD32, `ALU_OP_SUB32, `ALU_OP_AND32, `ALU_OP_OR32,
                                     `ALU_OP_XOR32, `ALU_OP_MOV32, `ALU_OP_CMOV32,
                                     `ALU_OP_CMOVN32};

  // sub is a + ~b + 1
  assign b_eff = sub_op ? ~d_b : d_b;
  assign a_x   = {1'b0, d_a};
  assign b_x   = {1'b0, b_eff};
  assign sum   = a_x + b_x + {{`ALU_W{1'b0}}, sub_op};

  assign carry[0] = a_x[4] ^ b_x[4] ^ sum[4]; // out of bit 3

  // widths 8, 16, 32, 64
  for (genvar i = 0; i < 4; i++) begin : g_width
    localparam int TOP = (8 << i) - 1;
    assign carry[i+1] = a_x[TOP+1] ^ b_x[TOP+1] ^ sum[TOP+1];
    assign ovf[i]     = (d_a[TOP] == b_eff[TOP]) && (sum[TOP] != d_a[TOP]);
    assign zero[i]    = (res_next[TOP:0] == '0);
    assign sign[i]    = res_next[TOP];
  end

  always_comb begin
    case (d_opcode)
      `ALU_OP_ZXT8_64:  ext_val = {{(`ALU_W-8){1'b0}}, d_b[7:0]};
      `ALU_OP_ZXT16_64: ext_val = {{(`ALU_W-16){1'b0}}, d_b[15:0]};
      `ALU_OP_SXT8_64:  ext_val = {{(`ALU_W-8){d_b[7]}}, d_b[7:0]};
      `ALU_OP_SXT16_64: ext_val = {{(`ALU_W-16){d_b[15]}}, d_b[15:0]};
      default:          ext_val = {{(`ALU_W-32){d_b[31]}}, d_b[31:0]};
    endcase
  end

  always_comb begin
    res_full = '0;
    if (sel_add)  res_full = sum[`ALU_W-1:0]; // cmp keeps the full difference
    if (sel_and)  res_full = d_a & d_b;
    if (sel_or)   res_full = d_a | d_b;
    if (sel_xor)  res_full = d_a ^ d_b;
    if (sel_mov)  res_full = d_b;
    if (sel_ext)  res_full = ext_val;
    if (sel_cmov) res_full = d_cond_true ? d_b : d_a;
    if (sel_cset) res_full = {{(`ALU_W-1){1'b0}}, d_cond_true};
    if (half)     res_full[`ALU_W-1:32] = '0;
  end

  assign res_next = (valid_next && !d_kill) ? res_full : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      x_valid    <= 1'b0;
      x_kill     <= 1'b0;
      x_no_flags <= 1'b0;
      x_result   <= '0;
    end else begin
      x_valid    <= valid_next;
      x_kill     <= d_kill;
      x_no_flags <= d_no_flags;
      x_result   <= res_next;
    end
  end

  always_ff @(posedge clk) begin
    x_thread    <= d_thread;
    x_opcode    <= d_opcode;
    x_carry     <= carry;
    x_ovf       <= ovf;
    x_sign_zero <= {zero, sign, even_parity8(res_next)};
  end

  a_one_unit: assert property (@(posedge clk) disable iff (rst)
    d_valid |-> $onehot0({sel_add, sel_and, sel_or, sel_xor, sel_mov, sel_ext, sel_cmov, sel_cset}));

  // every class is false on clear flags, so only the inverted forms hold
  a_cond_clear: assert property (@(posedge clk) disable iff (rst)
    d_valid && (sel_cmov || sel_cset) && (d_flags_in == '0) |-> d_cond_true == d_opcode[0]);

endmodule

`default_nettype wire

// File: src/alu_flags.sv
`default_nettype none

`include "alu_defines.svh"

module alu_flags (
  input  wire                      x_valid,
  input  wire                      x_kill,
  input  wire                      x_no_flags,
  input  wire  [`ALU_OPC_W-1:0]    x_opcode,
  input  wire  [`ALU_W-1:0]        x_result,
  input  wire  [`ALU_CARRY_W-1:0]  x_carry,
  input  wire  [`ALU_OVF_W-1:0]    x_ovf,
  input  wire  [`ALU_SZ_W-1:0]     x_sign_zero,
  output logic [`ALU_W-1:0]        res,
  output logic [`ALU_FLAGS_W-1:0]  ret_flags,
  output logic                     ret_sets_flags,
  output logic                     ret_en
);

  logic [1:0]              w;    // 0..3 for 8, 16, 32, 64 bits
  logic                    arith;
  logic                    borrow;
  logic                    logic_op;
  logic [`ALU_FLAGS_W-1:0] flags;

  always_comb begin
    w        = 2'd3;
    arith    = 1'b0;
    borrow   = 1'b0;
    logic_op = 1'b0;
    case (x_opcode)
      `ALU_OP_ADD64: arith = 1'b1;
      `ALU_OP_ADD32: begin
        arith = 1'b1;
        w     = 2'd2;
      end
      `ALU_OP_SUB64: begin
        arith  = 1'b1;
        borrow = 1'b1;
      end
      `ALU_OP_SUB32: begin
        arith  = 1'b1;
        borrow = 1'b1;
        w      = 2'd2;
      end
      `ALU_OP_CMP16: begin
        arith  = 1'b1;
        borrow = 1'b1;
        w      = 2'd1;
      end
      `ALU_OP_CMP8: begin
        arith  = 1'b1;
        borrow = 1'b1;
        w      = 2'd0;
      end
      `ALU_OP_AND64, `ALU_OP_OR64, `ALU_OP_XOR64: logic_op = 1'b1;
      `ALU_OP_AND32, `ALU_OP_OR32, `ALU_OP_XOR32: begin
        logic_op = 1'b1;
        w        = 2'd2;
      end
      default: ;
    endcase
  end

  // status layout is {zero[3:0], sign[3:0], parity}
  always_comb begin
    flags = '0;
    if (arith || logic_op) begin
      flags[`ALU_FLAG_S] = x_sign_zero[1 + w];
      flags[`ALU_FLAG_Z] = x_sign_zero[5 + w];
      flags[`ALU_FLAG_P] = x_sign_zero[0];
    end
    if (arith) begin
      flags[`ALU_FLAG_C] = x_carry[1 + w] ^ borrow;
      flags[`ALU_FLAG_O] = x_ovf[w];
      flags[`ALU_FLAG_A] = x_carry[0] ^ borrow;
    end
  end

  assign res            = x_result;
  assign ret_en         = x_valid && !x_kill;
  assign ret_sets_flags = ret_en && !x_no_flags;
  assign ret_flags      = ret_sets_flags ? flags : '0;

endmodule

`default_nettype wire

// File: src/alu_top.sv
`default_nettype none

`include "alu_defines.svh"

module alu_top (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      data_en,
  input  wire                      thread,
  input  wire alu_op_pkg::alu_op_u operation,
  input  wire  [`ALU_W-1:0]        val1,
  input  wire  [`ALU_W-1:0]        val2,
  input  wire  [`ALU_FLAGS_W-1:0]  flags_in,
  input  wire                      except,
  input  wire                      except_thread,
  output logic [`ALU_W-1:0]        res,
  output logic [`ALU_FLAGS_W-1:0]  ret_flags,
  output logic                     ret_sets_flags,
  output logic                     ret_en
);

  // decode to exec
  logic                    d_valid, d_thread, d_kill, d_no_flags;
  logic [`ALU_OPC_W-1:0]   d_opcode;
  logic [`ALU_W-1:0]       d_a, d_b;
  logic                    d_cond_true;
  logic [`ALU_FLAGS_W-1:0] d_flags_in;

  // exec to flags
  logic                    x_valid, x_thread, x_kill, x_no_flags;
  logic [`ALU_OPC_W-1:0]   x_opcode;
  logic [`ALU_W-1:0]       x_result;
  logic [`ALU_CARRY_W-1:0] x_carry;
  logic [`ALU_OVF_W-1:0]   x_ovf;
  logic [`ALU_SZ_W-1:0]    x_sign_zero;

  alu_decode u_decode (.*);

  alu_exec u_exec (.*);

  alu_flags u_flags (.*);

  // a returning op sat in exec last cycle and entered decode the cycle before
  a_except_drop: assert property (@(posedge clk) disable iff (rst)
    ret_en |-> !($past(except) && ($past(except_thread) == x_thread))
            && !($past(except, 2) && ($past(except_thread, 2) == x_thread)));

endmodule

`default_nettype wire

// File: dv/alu_tb_vectors.svh
// op_row: name, opcode, val1, val2, expected res, expected flags (C O A S Z P)
// cond_row: name, class, opcode, flags_in, val1, val2, expected res
// ctl_row: name, {no_flags, kill}, {thread, except, except_thread}, val1, val2, res, flags,
//   {ret_sets_flags, ret_en}
op_row("add64_carry", `ALU_OP_ADD64, 64'hffffffffffffffff, 64'h1, 64'h0, 6'h2b);
op_row("add64_ovf", `ALU_OP_ADD64, 64'h7fffffffffffffff, 64'h1, 64'h8000000000000000, 6'h1d);
op_row("add32_carry", `ALU_OP_ADD32, 64'h12345678fffffff0, 64'h11, 64'h1, 6'h20);
op_row("add32_ovf", `ALU_OP_ADD32, 64'h7fffffff, 64'h1, 64'h80000000, 6'h1d);
op_row("sub64_borrow", `ALU_OP_SUB64, 64'h1, 64'h2, 64'hffffffffffffffff, 6'h2d);
op_row("sub64_ovf", `ALU_OP_SUB64, 64'h8000000000000000, 64'h1, 64'h7fffffffffffffff, 6'h19);
op_row("sub32_zero", `ALU_OP_SUB32, 64'hdeadbeef00000005, 64'h5, 64'h0, 6'h03);
op_row("cmp16", `ALU_OP_CMP16, 64'h10000, 64'h1, 64'hffff, 6'h2d); // narrow borrow, wide result
op_row("cmp8", `ALU_OP_CMP8, 64'h1080, 64'h1, 64'h107f, 6'h18);
op_row("and64", `ALU_OP_AND64, 64'hf000000000000f0f, 64'h80000000000000ff,
       64'h800000000000000f, 6'h05);
op_row("or32", `ALU_OP_OR32, 64'hffffffff80000000, 64'h3, 64'h80000003, 6'h05);
op_row("xor64_zero", `ALU_OP_XOR64, 64'h5555aaaa12345678, 64'h5555aaaa12345678, 64'h0, 6'h03);
op_row("mov64", `ALU_OP_MOV64, 64'h0, 64'hcafef00d01234567, 64'hcafef00d01234567, 6'h00);
op_row("mov32", `ALU_OP_MOV32, 64'h0, 64'hcafef00d81234567, 64'h81234567, 6'h00);
op_row("zxt8", `ALU_OP_ZXT8_64, 64'h0, 64'hffffffffffffff80, 64'h80, 6'h00);
op_row("zxt16", `ALU_OP_ZXT16_64, 64'h0, 64'h123456789abcdef0, 64'hdef0, 6'h00);
op_row("sxt8", `ALU_OP_SXT8_64, 64'h0, 64'h80, 64'hffffffffffffff80, 6'h00);
op_row("sxt16", `ALU_OP_SXT16_64, 64'h0, 64'h8001, 64'hffffffffffff8001, 6'h00);
op_row("sxt32", `ALU_OP_SXT32_64, 64'h0, 64'h7fffffff80000000, 64'hffffffff80000000, 6'h00);
cond_row("cmov64_t", `ALU_COND_Z, `ALU_OP_CMOV64, 6'h02, 64'h1111, 64'h2222, 64'h2222);
cond_row("cmovn64_f", `ALU_COND_Z, `ALU_OP_CMOVN64, 6'h02, 64'h1111, 64'h2222, 64'h1111);
cond_row("cmov32_t", `ALU_COND_ULT, `ALU_OP_CMOV32, 6'h20,
         64'hf00000001, 64'he00000002, 64'h2);
cond_row("cmovn32_f", `ALU_COND_ULT, `ALU_OP_CMOVN32, 6'h20,
         64'hf00000001, 64'he00000002, 64'h1);
cond_row("cset_z", `ALU_COND_Z, `ALU_OP_CSET, 6'h02, 64'h0, 64'h0, 64'h1);
cond_row("csetn_z", `ALU_COND_Z, `ALU_OP_CSETN, 6'h02, 64'h0, 64'h0, 64'h0);
cond_row("cset_s", `ALU_COND_S, `ALU_OP_CSET, 6'h00, 64'h0, 64'h0, 64'h0);
cond_row("csetn_s", `ALU_COND_S, `ALU_OP_CSETN, 6'h00, 64'h0, 64'h0, 64'h1);
cond_row("cset_ule", `ALU_COND_ULE, `ALU_OP_CSET, 6'h20, 64'h0, 64'h0, 64'h1);
cond_row("csetn_ule", `ALU_COND_ULE, `ALU_OP_CSETN, 6'h02, 64'h0, 64'h0, 64'h0);
cond_row("cset_ult", `ALU_COND_ULT, `ALU_OP_CSET, 6'h20, 64'h0, 64'h0, 64'h1);
cond_row("csetn_ult", `ALU_COND_ULT, `ALU_OP_CSETN, 6'h20, 64'h0, 64'h0, 64'h0);
cond_row("cset_sle", `ALU_COND_SLE, `ALU_OP_CSET, 6'h04, 64'h0, 64'h0, 64'h1);
cond_row("csetn_sle", `ALU_COND_SLE, `ALU_OP_CSETN, 6'h14, 64'h0, 64'h0, 64'h1); // s == o
cond_row("cset_slt", `ALU_COND_SLT, `ALU_OP_CSET, 6'h10, 64'h0, 64'h0, 64'h1);
cond_row("csetn_slt", `ALU_COND_SLT, `ALU_OP_CSETN, 6'h04, 64'h0, 64'h0, 64'h0);
cond_row("cset_o", `ALU_COND_O, `ALU_OP_CSET, 6'h2f, 64'h0, 64'h0, 64'h0);
cond_row("csetn_o", `ALU_COND_O, `ALU_OP_CSETN, 6'h10, 64'h0, 64'h0, 64'h0);
cond_row("cset_p", `ALU_COND_P, `ALU_OP_CSET, 6'h3e, 64'h0, 64'h0, 64'h0);
cond_row("csetn_p", `ALU_COND_P, `ALU_OP_CSETN, 6'h01, 64'h0, 64'h0, 64'h0);
ctl_row("kill", 2'b01, 3'b000, 64'h5, 64'h6, 64'h0, 6'h00, 2'b00);
ctl_row("no_flags", 2'b10, 3'b000, 64'h2, 64'h3, 64'h5, 6'h00, 2'b01);
// thread 1 raises on its own entry cycle
ctl_row("exc_now", 2'b00, 3'b111, 64'h1, 64'h1, 64'h0, 6'h00, 2'b00);
// next row raises for thread 1 while this one sits in exec
ctl_row("exc_next_victim", 2'b00, 3'b100, 64'h1, 64'h2, 64'h0, 6'h00, 2'b00);
ctl_row("exc_next_src", 2'b00, 3'b011, 64'h2, 64'h2, 64'h4, 6'h00, 2'b11);
ctl_row("exc_other", 2'b00, 3'b011, 64'h3, 64'h4, 64'h7, 6'h00, 2'b11);
// thread 0 raises two cycles after this one entered
ctl_row("exc_late_victim", 2'b00, 3'b000, 64'h8, 64'h8, 64'h10, 6'h08, 2'b11);
ctl_row("exc_late_mid", 2'b00, 3'b100, 64'h1, 64'h0, 64'h1, 6'h00, 2'b11);
ctl_row("exc_late_src", 2'b00, 3'b110, 64'h0, 64'h0, 64'h0, 6'h03, 2'b11);

// File: dv/alu_tb.sv
`default_nettype none

`include "alu_defines.svh"

module alu_tb;
  import alu_op_pkg::*;

  typedef struct {
    string       name;
    logic [12:0] op;
    logic [2:0]  ctl;  // thread, except, except_thread
    logic [63:0] a;
    logic [63:0] b;
    logic [5:0]  fin;
    logic [63:0] res;
    logic [5:0]  fl;
    logic [1:0]  se;   // ret_sets_flags, ret_en
  } row_t;

  logic                    clk;
  logic                    rst;
  logic                    data_en;
  logic                    thread;
  alu_op_u                 operation;
  logic [`ALU_W-1:0]       val1;
  logic [`ALU_W-1:0]       val2;
  logic [`ALU_FLAGS_W-1:0] flags_in;
  logic                    except;
  logic                    except_thread;
  wire  [`ALU_W-1:0]       res;
  wire  [`ALU_FLAGS_W-1:0] ret_flags;
  wire                     ret_sets_flags;
  wire                     ret_en;

  row_t rows[$];
  int   checks;
  int   errors;

  alu_top DUT (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic push_row(string name, logic [12:0] op, logic [2:0] ctl, logic [63:0] a,
                          logic [63:0] b, logic [5:0] fin, logic [63:0] r, logic [5:0] fl,
                          logic [1:0] se);
    rows.push_back(row_t'{name, op, ctl, a, b, fin, r, fl, se});
  endtask

  task automatic op_row(string name, logic [7:0] opc, logic [63:0] a, logic [63:0] b,
                        logic [63:0] r, logic [5:0] fl);
    push_row(name, {5'b00000, opc}, 3'b000, a, b, 6'h00, r, fl, 2'b11);
  endtask

  // sub field carries the condition class
  task automatic cond_row(string name, logic [2:0] cls, logic [7:0] opc, logic [5:0] fin,
                          logic [63:0] a, logic [63:0] b, logic [63:0] r);
    push_row(name, {2'b00, cls, opc}, 3'b000, a, b, fin, r, 6'h00, 2'b11);
  endtask

  task automatic ctl_row(string name, logic [1:0] nfk, logic [2:0] ctl, logic [63:0] a,
                         logic [63:0] b, logic [63:0] r, logic [5:0] fl, logic [1:0] se);
    push_row(name, {nfk, 3'b000, `ALU_OP_ADD64}, ctl, a, b, 6'h00, r, fl, se);
  endtask

  task automatic load_table;
    `include "alu_tb_vectors.svh"
  endtask

  task automatic drive_row(int i);
    if (i < rows.size()) begin
      data_en       = 1'b1;
      operation     = rows[i].op;
      thread        = rows[i].ctl[2];
      except        = rows[i].ctl[1];
      except_thread = rows[i].ctl[0];
      val1          = rows[i].a;
      val2          = rows[i].b;
      flags_in      = rows[i].fin;
    end else begin
      data_en = 1'b0; // drain
      except  = 1'b0;
    end
  endtask

  task automatic check_out(string name, logic [63:0] e_res, logic [5:0] e_fl,
                           logic [1:0] e_se);
    checks++;
    assert (res === e_res) else begin
      errors++;
      $display("CHECK FAILED %s res expected %h actual %h", name, e_res, res);
    end
    assert (ret_flags === e_fl) else begin
      errors++;
      $display("CHECK FAILED %s ret_flags expected %b actual %b", name, e_fl, ret_flags);
    end
    assert ({ret_sets_flags, ret_en} === e_se) else begin
      errors++;
      $display("CHECK FAILED %s sets_flags,ret_en expected %b actual %b", name, e_se,
               {ret_sets_flags, ret_en});
    end
  endtask

  initial begin
    rst           = 1'b1;
    data_en       = 1'b0;
    thread        = 1'b0;
    operation     = '0;
    val1          = '0;
    val2          = '0;
    flags_in      = '0;
    except        = 1'b0;
    except_thread = 1'b0;
    checks        = 0;
    errors        = 0;
    load_table();
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    check_out("reset", '0, '0, 2'b00);
    // a row driven now returns two edges later
    for (int k = 0; k < rows.size() + 2; k++) begin
      if (k >= 2) begin
        check_out(rows[k-2].name, rows[k-2].res, rows[k-2].fl, rows[k-2].se);
      end
      drive_row(k);
      @(posedge clk);
      #2;
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #1;
    #((rows.size() + 20) * 20);
    $display("timeout, the vector table did not finish in time");
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: alu_pipe.f
+incdir+src
+incdir+dv
src/alu_op_pkg.sv
src/alu_flag_pkg.sv
src/alu_decode.sv
src/alu_exec.sv
src/alu_flags.sv
src/alu_top.sv
dv/alu_tb.sv

// File: Bender.yml
package:
  name: alu_pipe

sources:
  - include_dirs:
      - src
    files:
      - src/alu_op_pkg.sv
      - src/alu_flag_pkg.sv
      - src/alu_decode.sv
      - src/alu_exec.sv
      - src/alu_flags.sv
      - src/alu_top.sv
  - target: test
    include_dirs:
      - src
      - dv
    files:
      - dv/alu_tb.sv
